// File: Makefile
SRCS = exec_pkg.sv result_queue.sv fu_alu.sv fu_mul.sv cdb_arbiter.sv exec_unit.sv \
       exec_unit_checker.sv exec_monitor.sv exec_unit_tb.sv

.PHONY: run clean

run: obj_dir/Vexec_unit_tb exec_stim.txt
	./obj_dir/Vexec_unit_tb +verilator+error+limit+100 | tee sim.log
	@grep -q "Test completed successfully" sim.log

obj_dir/Vexec_unit_tb: $(SRCS) flist.f
	verilator --binary --timing --assert -Wno-fatal --top-module exec_unit_tb -f flist.f

clean:
	rm -rf obj_dir sim.log

// File: cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter (
    input  logic           clk,
    input  logic           rst,
    input  logic           alu_rdy,
    input  logic           mul_rdy,
    input  exec_pkg::cdb_t alu_head,
    input  exec_pkg::cdb_t mul_head,
    input  logic           cdb_credit,
    output logic           alu_pop,
    output logic           mul_pop,
    output logic           cdb_valid,
    output exec_pkg::cdb_t cdb
);
    import exec_pkg::*;

    localparam int CW = $clog2(CDB_CREDITS + 1);

    logic [CW-1:0] credits;
    logic          has_credit;
    logic          send;

    // A beat on the bus still holds its credit until the cycle ends,
    // so it must be left out of what is free to spend.
    assign has_credit = cdb_valid ? (credits > CW'(1)) : (credits != '0);

    assign mul_pop = has_credit && mul_rdy;
    assign alu_pop = has_credit && alu_rdy && !mul_rdy;
    assign send    = mul_pop || alu_pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits   <= CW'(CDB_CREDITS);
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= send;
            if (cdb_credit && !cdb_valid) begin
                credits <= credits + 1'b1;
            end else if (!cdb_credit && cdb_valid) begin
                credits <= credits - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            cdb <= mul_pop ? mul_head : alu_head;
        end
    end

endmodule

// File: exec_monitor.sv
`timescale 1ns/100ps

module exec_monitor (
    input  logic           clk,
    input  logic           rst,
    input  logic           cdb_valid,
    input  exec_pkg::cdb_t cdb,
    input  logic           cdb_credit,
    input  logic           exp_valid,
    input  exec_pkg::cdb_t exp_entry,
    output int             passed,
    output int             failed,
    output int             errors
);
    import exec_pkg::*;

    cdb_t expected [64];
    logic pending [64];
    int   outstanding;

    // Everything is sampled on the falling edge, away from the drive times.
    always @(negedge clk) begin
        if (rst) begin
            passed = 0;
            failed = 0;
            errors = 0;
            outstanding = 0;
            for (int i = 0; i < 64; i++) begin
                pending[i] = 1'b0;
            end
        end else begin
            if (exp_valid) begin
                expected[exp_entry.rob_idx] = exp_entry;
                pending[exp_entry.rob_idx] = 1'b1;
            end
            outstanding = outstanding + int'(cdb_valid) - int'(cdb_credit);
            if (outstanding > CDB_CREDITS) begin
                $display("** Error at %0t: %0d CDB beats outstanding, limit %0d",
                         $time, outstanding, CDB_CREDITS);
                errors++;
            end
            if (cdb_valid) begin
                if (!pending[cdb.rob_idx]) begin
                    $display("** Error at %0t: unexpected result for rob %0d",
                             $time, cdb.rob_idx);
                    errors++;
                end else if (cdb !== expected[cdb.rob_idx]) begin
                    $display(
                        "** Error at %0t: rob %0d expected pd %0d rd %0d %h, got pd %0d rd %0d %h",
                        $time, cdb.rob_idx, expected[cdb.rob_idx].pd,
                        expected[cdb.rob_idx].rd, expected[cdb.rob_idx].rd_v,
                        cdb.pd, cdb.rd, cdb.rd_v);
                    pending[cdb.rob_idx] = 1'b0;
                    failed++;
                end else begin
                    $display("PASS rob %0d pd %0d rd %0d value %h",
                             cdb.rob_idx, cdb.pd, cdb.rd, cdb.rd_v);
                    pending[cdb.rob_idx] = 1'b0;
                    passed++;
                end
            end
        end
    end

endmodule

// File: exec_pkg.sv
package exec_pkg;

    // --------------------
    // Widths
    // --------------------
    typedef logic [31:0] word_t;
    typedef logic [5:0]  rob_idx_t;
    typedef logic [5:0]  preg_t;
    typedef logic [4:0]  areg_t;
    typedef logic [3:0]  op_t;

    // --------------------
    // Opcodes
    // --------------------
    localparam op_t OP_ADD    = 4'h0;
    localparam op_t OP_SUB    = 4'h1;
    localparam op_t OP_AND    = 4'h2;
    localparam op_t OP_OR     = 4'h3;
    localparam op_t OP_XOR    = 4'h4;
    localparam op_t OP_SLT    = 4'h5;
    localparam op_t OP_SLTU   = 4'h6;
    localparam op_t OP_SLL    = 4'h7;
    localparam op_t OP_SRL    = 4'h8;
    localparam op_t OP_SRA    = 4'h9;
    localparam op_t OP_MUL    = 4'hA;
    localparam op_t OP_MULH   = 4'hB;
    localparam op_t OP_MULHSU = 4'hC;
    localparam op_t OP_MULHU  = 4'hD;

    // Credit depths. The unit depths match their result queues.
    localparam int ALU_CREDITS = 2;
    localparam int MUL_CREDITS = 4;
    localparam int CDB_CREDITS = 2;

    typedef struct packed {
        rob_idx_t rob_idx;
        preg_t    pd;
        areg_t    rd;
        op_t      op;
        word_t    rs1_v;
        word_t    rs2_v;
    } issue_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        preg_t    pd;
        areg_t    rd;
        word_t    rd_v;
    } cdb_t;

endpackage

// File: exec_stim.txt
# unit (0 ALU, 1 MUL), op, rs1, rs2, rob_idx, pd, rd, expected rd_v: all hex
# last column: consumer hold cycles before the CDB credit returns, decimal
0 0 7fffffff 00000001 00 20 01 80000000 0
0 1 00000000 00000001 01 21 02 ffffffff 1
1 a ffffffff ffffffff 02 22 03 00000001 0
0 2 f0f0f0f0 ff00ff00 03 23 04 f000f000 2
1 b 80000000 80000000 04 24 05 40000000 0
0 3 f0f0f0f0 0f0f0f0f 05 25 06 ffffffff 0
1 c ffffffff ffffffff 06 26 07 ffffffff 3
0 4 aaaaaaaa ffffffff 07 27 08 55555555 0
1 d ffffffff ffffffff 08 28 09 fffffffe 1
0 5 ffffffff 00000001 09 29 0a 00000001 40
0 6 ffffffff 00000001 0a 2a 0b 00000000 40
1 a 12345678 00000009 0b 2b 0c a3d70a38 0
0 7 00000001 00000021 0c 2c 0d 00000002 0
1 b fffffffe 00000003 0d 2d 0e ffffffff 2
0 8 80000000 00000004 0e 2e 0f 08000000 0
1 c 00000002 80000000 0f 2f 10 00000001 0
0 9 80000000 00000004 10 30 11 f8000000 0
0 9 80000000 0000003f 11 31 12 ffffffff 1
1 a 7fffffff 7fffffff 12 32 13 00000001 0
0 0 00001000 00000234 13 33 1f 00001234 0

// File: exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             alu_issue_valid,
    input  exec_pkg::issue_t alu_issue,
    input  logic             mul_issue_valid,
    input  exec_pkg::issue_t mul_issue,
    input  logic             cdb_credit,
    output logic             alu_credit,
    output logic             mul_credit,
    output logic             cdb_valid,
    output exec_pkg::cdb_t   cdb
);
    import exec_pkg::*;

    logic alu_rdy;
    logic mul_rdy;
    cdb_t alu_head;
    cdb_t mul_head;

    // A queue pop frees one slot, which goes straight back to the issuer.
    fu_alu alu_i (
        .clk        (clk),
        .rst        (rst),
        .issue_valid(alu_issue_valid),
        .issue      (alu_issue),
        .pop        (alu_credit),
        .rdy        (alu_rdy),
        .head       (alu_head)
    );

    fu_mul mul_i (
        .clk        (clk),
        .rst        (rst),
        .issue_valid(mul_issue_valid),
        .issue      (mul_issue),
        .pop        (mul_credit),
        .rdy        (mul_rdy),
        .head       (mul_head)
    );

    cdb_arbiter arb_i (
        .clk       (clk),
        .rst       (rst),
        .alu_rdy   (alu_rdy),
        .mul_rdy   (mul_rdy),
        .alu_head  (alu_head),
        .mul_head  (mul_head),
        .cdb_credit(cdb_credit),
        .alu_pop   (alu_credit),
        .mul_pop   (mul_credit),
        .cdb_valid (cdb_valid),
        .cdb       (cdb)
    );

endmodule

// File: exec_unit_checker.sv
`timescale 1ns/100ps

module exec_unit_checker (
    input logic                                         clk,
    input logic                                         rst,
    input logic                                         cdb_valid,
    input logic                                         alu_push,
    input logic [$clog2(exec_pkg::ALU_CREDITS + 1)-1:0] alu_count,
    input logic                                         mul_push,
    input logic [$clog2(exec_pkg::MUL_CREDITS + 1)-1:0] mul_count,
    input logic [$clog2(exec_pkg::CDB_CREDITS + 1)-1:0] credits
);
    import exec_pkg::*;

    int fail_count = 0;

    reset_quiet: assert property (@(posedge clk) $past(rst) |-> !cdb_valid)
        else begin $error("cdb_valid high during reset"); fail_count++; end

    alu_no_overflow: assert property (@(posedge clk) disable iff (rst)
        alu_push |-> int'(alu_count) < ALU_CREDITS)
        else begin $error("ALU result queue pushed while full"); fail_count++; end

    mul_no_overflow: assert property (@(posedge clk) disable iff (rst)
        mul_push |-> int'(mul_count) < MUL_CREDITS)
        else begin $error("multiplier result queue pushed while full"); fail_count++; end

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        int'(credits) <= CDB_CREDITS)
        else begin $error("arbiter holds more CDB credits than issued"); fail_count++; end

    send_needs_credit: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> credits != '0)
        else begin $error("cdb_valid with zero CDB credits"); fail_count++; end

endmodule

// File: exec_unit_tb.sv
`timescale 1ns/100ps

module exec_unit_tb;
    import exec_pkg::*;

    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 2000;

    logic   clk;
    logic   rst;
    logic   alu_issue_valid;
    issue_t alu_issue;
    logic   mul_issue_valid;
    issue_t mul_issue;
    logic   cdb_credit;
    logic   alu_credit;
    logic   mul_credit;
    logic   cdb_valid;
    cdb_t   cdb;
    logic   exp_valid;
    cdb_t   exp_entry;
    int     passed;
    int     failed;
    int     errors;
    int     cyc = 0;
    int     alu_spent = 0;
    int     mul_spent = 0;
    int     alu_returned = 0;
    int     mul_returned = 0;
    int     hold_by_rob [64];
    int     due_q [$];
    int     total = 0;
    logic   run_error = 1'b0;

    exec_unit dut_i (.*);

    exec_monitor mon_i (.*);

    bind exec_unit exec_unit_checker chk_i (
        .clk      (clk),
        .rst      (rst),
        .cdb_valid(cdb_valid),
        .alu_push (alu_i.res_valid),
        .alu_count(alu_i.queue_i.count),
        .mul_push (mul_i.s3_valid),
        .mul_count(mul_i.queue_i.count),
        .credits  (arb_i.credits)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic int free_credits(input logic is_mul);
        if (is_mul) begin
            return MUL_CREDITS - mul_spent + mul_returned;
        end
        return ALU_CREDITS - alu_spent + alu_returned;
    endfunction

    task automatic issue_entry(input logic is_mul, input issue_t item, input word_t value);
        int waited;
        waited = 0;
        while (free_credits(is_mul) == 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (free_credits(is_mul) == 0) begin
            $display("Timeout: no %s credit came back within %0d cycles",
                     is_mul ? "multiplier" : "ALU", WAIT_LIMIT);
            run_error = 1'b1;
        end else begin
            if (is_mul) begin
                mul_issue_valid = 1'b1;
                mul_issue = item;
                mul_spent++;
            end else begin
                alu_issue_valid = 1'b1;
                alu_issue = item;
                alu_spent++;
            end
            exp_valid = 1'b1;
            exp_entry.rob_idx = item.rob_idx;
            exp_entry.pd = item.pd;
            exp_entry.rd = item.rd;
            exp_entry.rd_v = value;
            @(posedge clk);
            #2;
            alu_issue_valid = 1'b0;
            mul_issue_valid = 1'b0;
            exp_valid = 1'b0;
        end
    endtask

    // --------------------
    // Consumer and credit return model
    // --------------------
    initial begin : consumer
        cdb_credit = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (cdb_valid) begin
                    due_q.push_back(cyc + hold_by_rob[cdb.rob_idx]);
                end
                if (alu_credit) alu_returned++;
                if (mul_credit) mul_returned++;
            end
            @(posedge clk);
            #2;
            cdb_credit = 1'b0;
            // At most one credit per cycle goes back.
            for (int i = 0; i < due_q.size(); i++) begin
                if (due_q[i] <= cyc && !cdb_credit) begin
                    cdb_credit = 1'b1;
                    due_q.delete(i);
                end
            end
        end
    end

    initial begin : stimulus
        int          fd;
        int          fields;
        int          waited;
        int          gap;
        int          f_hold;
        string       line;
        logic [31:0] f_unit;
        logic [31:0] f_op;
        logic [31:0] f_rs1;
        logic [31:0] f_rs2;
        logic [31:0] f_rob;
        logic [31:0] f_pd;
        logic [31:0] f_rd;
        logic [31:0] f_exp;
        issue_t      item;

        clk = 1'b0;
        rst = 1'b1;
        alu_issue_valid = 1'b0;
        alu_issue = '0;
        mul_issue_valid = 1'b0;
        mul_issue = '0;
        exp_valid = 1'b0;
        exp_entry = '0;
        void'($urandom(32'h4817_4b90));
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        fd = $fopen("exec_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file exec_stim.txt");
            run_error = 1'b1;
        end
        while (fd != 0 && !$feof(fd) && !run_error) begin
            line = "";
            fields = $fgets(line, fd);
            if (fields > 0 && line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %d", f_unit, f_op,
                                 f_rs1, f_rs2, f_rob, f_pd, f_rd, f_exp, f_hold);
                if (fields == 9) begin
                    gap = int'($urandom % 3);
                    repeat (gap) begin
                        @(posedge clk);
                        #2;
                    end
                    item.rob_idx = rob_idx_t'(f_rob);
                    item.pd = preg_t'(f_pd);
                    item.rd = areg_t'(f_rd);
                    item.op = op_t'(f_op);
                    item.rs1_v = f_rs1;
                    item.rs2_v = f_rs2;
                    hold_by_rob[item.rob_idx] = f_hold;
                    issue_entry(f_unit[0], item, f_exp);
                    total++;
                end
            end
        end
        if (fd != 0) $fclose(fd);

        waited = 0;
        while (passed + failed < total && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (passed + failed < total) begin
            $display("Timeout: %0d of %0d results never reached the CDB",
                     total - passed - failed, total);
            run_error = 1'b1;
        end

        waited = 0;
        while ((alu_returned != alu_spent || mul_returned != mul_spent || due_q.size() != 0)
               && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (alu_returned != alu_spent || mul_returned != mul_spent) begin
            $display("Issue credits did not all come back: ALU %0d of %0d, MUL %0d of %0d",
                     alu_returned, alu_spent, mul_returned, mul_spent);
            run_error = 1'b1;
        end

        $display("Summary: %0d passed, %0d failed, %0d missing, %0d errors, %0d assertion fails",
                 passed, failed, total - passed - failed, errors, dut_i.chk_i.fail_count);
        if (failed == 0 && errors == 0 && !run_error && dut_i.chk_i.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
exec_pkg.sv
result_queue.sv
fu_alu.sv
fu_mul.sv
cdb_arbiter.sv
exec_unit.sv
exec_unit_checker.sv
exec_monitor.sv
exec_unit_tb.sv

// File: fu_alu.sv
`timescale 1ns/100ps

module fu_alu (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_valid,
    input  exec_pkg::issue_t issue,
    input  logic             pop,
    output logic             rdy,
    output exec_pkg::cdb_t   head
);
    import exec_pkg::*;

    word_t      alu_out;
    logic [4:0] shamt;
    logic       res_valid;
    cdb_t       res;

    assign shamt = issue.rs2_v[4:0];

    always_comb begin
        unique case (issue.op)
            OP_ADD:  alu_out = issue.rs1_v + issue.rs2_v;
            OP_SUB:  alu_out = issue.rs1_v - issue.rs2_v;
            OP_AND:  alu_out = issue.rs1_v & issue.rs2_v;
            OP_OR:   alu_out = issue.rs1_v | issue.rs2_v;
            OP_XOR:  alu_out = issue.rs1_v ^ issue.rs2_v;
            OP_SLT:  alu_out = {31'd0, $signed(issue.rs1_v) < $signed(issue.rs2_v)};
            OP_SLTU: alu_out = {31'd0, issue.rs1_v < issue.rs2_v};
            OP_SLL:  alu_out = issue.rs1_v << shamt;
            OP_SRL:  alu_out = issue.rs1_v >> shamt;
            OP_SRA:  alu_out = word_t'($signed(issue.rs1_v) >>> shamt);
            default: alu_out = '0;
        endcase
    end

    // The result register gives the one extra cycle before the queue.
    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            res.rob_idx <= issue.rob_idx;
            res.pd      <= issue.pd;
            res.rd      <= issue.rd;
            res.rd_v    <= alu_out;
        end
    end

    result_queue #(
        .DEPTH(ALU_CREDITS)
    ) queue_i (
        .clk (clk),
        .rst (rst),
        .push(res_valid),
        .din (res),
        .pop (pop),
        .rdy (rdy),
        .head(head)
    );

endmodule

// File: fu_mul.sv
`timescale 1ns/100ps

module fu_mul (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_valid,
    input  exec_pkg::issue_t issue,
    input  logic             pop,
    output logic             rdy,
    output exec_pkg::cdb_t   head
);
    import exec_pkg::*;

    logic               sign_a;
    logic               sign_b;
    logic signed [65:0] prod;

    logic               s1_valid, s2_valid, s3_valid;
    rob_idx_t           s1_rob, s2_rob;
    preg_t              s1_pd, s2_pd;
    areg_t              s1_rd, s2_rd;
    logic               s1_hi, s2_hi;
    logic signed [32:0] s1_a, s1_b;
    logic        [63:0] s2_prod;
    cdb_t               s3_res;

    // MULHU treats both operands as unsigned, MULHSU only the second.
    assign sign_a = (issue.op != OP_MULHU) && issue.rs1_v[31];
    assign sign_b = ((issue.op == OP_MUL) || (issue.op == OP_MULH)) && issue.rs2_v[31];
    assign prod   = s1_a * s1_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // --------------------
    // Pipeline payload
    // --------------------
    always_ff @(posedge clk) begin
        s1_rob  <= issue.rob_idx;
        s1_pd   <= issue.pd;
        s1_rd   <= issue.rd;
        s1_hi   <= (issue.op != OP_MUL);
        s1_a    <= {sign_a, issue.rs1_v};
        s1_b    <= {sign_b, issue.rs2_v};

        s2_rob  <= s1_rob;
        s2_pd   <= s1_pd;
        s2_rd   <= s1_rd;
        s2_hi   <= s1_hi;
        s2_prod <= prod[63:0];

        s3_res.rob_idx <= s2_rob;
        s3_res.pd      <= s2_pd;
        s3_res.rd      <= s2_rd;
        s3_res.rd_v    <= s2_hi ? s2_prod[63:32] : s2_prod[31:0];
    end

    result_queue #(
        .DEPTH(MUL_CREDITS)
    ) queue_i (
        .clk (clk),
        .rst (rst),
        .push(s3_valid),
        .din (s3_res),
        .pop (pop),
        .rdy (rdy),
        .head(head)
    );

endmodule

// File: result_queue.sv
`timescale 1ns/100ps

module result_queue #(
    parameter int DEPTH = 2
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           push,
    input  exec_pkg::cdb_t din,
    input  logic           pop,
    output logic           rdy,
    output exec_pkg::cdb_t head
);
    import exec_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    cdb_t             mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    assign rdy    = (count != '0);
    assign head   = mem[rd_ptr];
    assign do_pop = pop && rdy;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !do_pop) begin
                count <= count + 1'b1;
            end else if (!push && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule
